// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_decode_stage \
		-Mdir obj_dir -f build.f
	./obj_dir/Vtb_decode_stage | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" sim.log; then \
		echo "Simulation ended without a status"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: build.f
hdl/rv_decode_pkg.sv
hdl/op_decoder.sv
hdl/operand_select.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
testbench/decode_chk.sv
testbench/decode_monitor.sv
testbench/tb_decode_stage.sv

// File: hdl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  logic [xlen-1:0]       instr_i,
    input  logic [xlen-1:0]       pc_i,
    input  logic [xlen-1:0]       rs1_data_i,
    input  logic [xlen-1:0]       rs2_data_i,
    output logic [reg_addr_w-1:0] rs1_o,
    output logic [reg_addr_w-1:0] rs2_o,
    output logic                  hazard_o,
    output op_e                   op_o,
    output logic [xlen-1:0]       operand1_o,
    output logic [xlen-1:0]       operand2_o,
    output logic [xlen-1:0]       operand3_o,
    output logic [xlen-1:0]       pc_o,
    output logic [xlen-1:0]       instr_o,
    output logic [reg_addr_w-1:0] rd_o,
    output logic                  exc_illegal_o,
    output logic                  exc_misaligned_o
);

    logic [xlen-1:0]       cur_instr;
    format_e               fmt;
    op_e                   op;
    logic                  illegal;
    logic                  misaligned;
    logic                  hazard;
    logic [reg_addr_w-1:0] locked_rd;
    logic [xlen-1:0]       operand1;
    logic [xlen-1:0]       operand2;
    logic [xlen-1:0]       operand3;

    hazard_unit hazard_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .enable_i    (enable_i),
        .instr_i     (instr_i),
        .fmt_i       (fmt),
        .cur_instr_o (cur_instr),
        .hazard_o    (hazard),
        .locked_rd_o (locked_rd)
    );

    op_decoder op_decoder_inst (
        .instr_i   (cur_instr),
        .op_o      (op),
        .fmt_o     (fmt),
        .illegal_o (illegal)
    );

    operand_select operand_select_inst (
        .instr_i    (cur_instr),
        .fmt_i      (fmt),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .operand1_o (operand1),
        .operand2_o (operand2),
        .operand3_o (operand3)
    );

    // Register file read addresses
    assign rs1_o = cur_instr[19:15];
    assign rs2_o = cur_instr[24:20];

    assign hazard_o   = hazard;
    assign misaligned = (pc_i[1:0] != 2'b00);

    // Lock loads on the same edge as the outputs, so rd matches op_o
    assign rd_o = locked_rd;

    ////////////////////////////////////////
    // Stage output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || hazard) begin
            // Idle values double as the bubble
            op_o             <= op_nop;
            operand1_o       <= '0;
            operand2_o       <= '0;
            operand3_o       <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (enable_i) begin
            op_o             <= op;
            operand1_o       <= operand1;
            operand2_o       <= operand2;
            operand3_o       <= operand3;
            pc_o             <= pc_i;
            instr_o          <= cur_instr;
            exc_illegal_o    <= illegal;
            exc_misaligned_o <= misaligned;
        end
    end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit
    import rv_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  logic [xlen-1:0]       instr_i,
    input  format_e               fmt_i,
    output logic [xlen-1:0]       cur_instr_o,
    output logic                  hazard_o,
    output logic [reg_addr_w-1:0] locked_rd_o
);

    logic [xlen-1:0]       last_instr;
    logic                  last_hazard;
    logic                  last_stall;
    logic                  locked_store;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  writes_rd;
    logic                  is_load;
    logic                  is_store;

    ////////////////////////////////////////
    // Replay of the held instruction
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= cur_instr_o;
        if (reset) begin
            last_hazard <= 1'b0;
            last_stall  <= 1'b0;
        end else begin
            last_hazard <= hazard_o;
            last_stall  <= ~enable_i;
        end
    end

    assign cur_instr_o = (last_hazard | last_stall) ? last_instr : instr_i;

    assign rs1      = cur_instr_o[19:15];
    assign rs2      = cur_instr_o[24:20];
    assign is_load  = (cur_instr_o[6:0] == opc_load);
    assign is_store = (cur_instr_o[6:0] == opc_store);

    // S and B carry immediate bits where rd would be
    assign writes_rd = (fmt_i != s_type) && (fmt_i != b_type);
    assign use_rs1   = (fmt_i != u_type) && (fmt_i != j_type);
    assign use_rs2   = (fmt_i == r_type) || (fmt_i == s_type) || (fmt_i == b_type);

    ////////////////////////////////////////
    // One-deep register and memory lock
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || hazard_o) begin
            locked_rd_o  <= '0;
            locked_store <= 1'b0;
        end else if (enable_i) begin
            locked_rd_o  <= writes_rd ? cur_instr_o[11:7] : '0;
            locked_store <= is_store;
        end
    end

    // x0 never locks anything
    assign hazard_o = enable_i & (
        (use_rs1 && rs1 == locked_rd_o && locked_rd_o != '0) ||
        (use_rs2 && rs2 == locked_rd_o && locked_rd_o != '0) ||
        (is_load && locked_store));

endmodule

// File: hdl/op_decoder.sv
`timescale 1ns/100ps

module op_decoder
    import rv_decode_pkg::*;
(
    input  logic [xlen-1:0] instr_i,
    output op_e             op_o,
    output format_e         fmt_o,
    output logic            illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    op_e dec_branch;
    op_e dec_load;
    op_e dec_store;
    op_e dec_op_imm;
    op_e dec_op;
    op_e dec_misc_mem;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Sub-tables per major opcode
    ////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  dec_branch = op_beq;
            3'b001:  dec_branch = op_bne;
            3'b100:  dec_branch = op_blt;
            3'b101:  dec_branch = op_bge;
            3'b110:  dec_branch = op_bltu;
            3'b111:  dec_branch = op_bgeu;
            default: dec_branch = op_invalid;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_load = op_lb;
            3'b001:  dec_load = op_lh;
            3'b010:  dec_load = op_lw;
            3'b100:  dec_load = op_lbu;
            3'b101:  dec_load = op_lhu;
            default: dec_load = op_invalid;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_store = op_sb;
            3'b001:  dec_store = op_sh;
            3'b010:  dec_store = op_sw;
            default: dec_store = op_invalid;
        endcase
    end

    // Shift immediates still need a clean funct7
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????000: dec_op_imm = op_add;
            10'b0000000001: dec_op_imm = op_sll;
            10'b???????010: dec_op_imm = op_slt;
            10'b???????011: dec_op_imm = op_sltu;
            10'b???????100: dec_op_imm = op_xor;
            10'b0000000101: dec_op_imm = op_srl;
            10'b0100000101: dec_op_imm = op_sra;
            10'b???????110: dec_op_imm = op_or;
            10'b???????111: dec_op_imm = op_and;
            default:        dec_op_imm = op_invalid;
        endcase
    end

    // Multiply/divide (funct7 0000001) falls through to invalid
    always_comb begin
        case ({funct7, funct3})
            10'b0000000000: dec_op = op_add;
            10'b0100000000: dec_op = op_sub;
            10'b0000000001: dec_op = op_sll;
            10'b0000000010: dec_op = op_slt;
            10'b0000000011: dec_op = op_sltu;
            10'b0000000100: dec_op = op_xor;
            10'b0000000101: dec_op = op_srl;
            10'b0100000101: dec_op = op_sra;
            10'b0000000110: dec_op = op_or;
            10'b0000000111: dec_op = op_and;
            default:        dec_op = op_invalid;
        endcase
    end

    // FENCE only
    assign dec_misc_mem = (funct3 == 3'b000) ? op_nop : op_invalid;

    ////////////////////////////////////////
    // Major opcode
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            opc_lui:      op_o = op_lui;
            opc_auipc:    op_o = op_add;
            opc_jal:      op_o = op_jal;
            opc_jalr:     op_o = op_jalr;
            opc_branch:   op_o = dec_branch;
            opc_load:     op_o = dec_load;
            opc_store:    op_o = dec_store;
            opc_op_imm:   op_o = dec_op_imm;
            opc_op:       op_o = dec_op;
            opc_misc_mem: op_o = dec_misc_mem;
            // SYSTEM and anything unlisted
            default:      op_o = op_invalid;
        endcase
    end

    assign illegal_o = (op_o == op_invalid);

    // Format from opcode bits 6 to 2, R for everything else
    always_comb begin
        case (opcode[6:2])
            opc_jalr[6:2], opc_load[6:2], opc_op_imm[6:2]: fmt_o = i_type;
            opc_store[6:2]:                                fmt_o = s_type;
            opc_branch[6:2]:                               fmt_o = b_type;
            opc_lui[6:2], opc_auipc[6:2]:                  fmt_o = u_type;
            opc_jal[6:2]:                                  fmt_o = j_type;
            default:                                       fmt_o = r_type;
        endcase
    end

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/100ps

module operand_select
    import rv_decode_pkg::*;
(
    input  logic [xlen-1:0] instr_i,
    input  format_e         fmt_i,
    input  logic [xlen-1:0] pc_i,
    input  logic [xlen-1:0] rs1_data_i,
    input  logic [xlen-1:0] rs2_data_i,
    output logic [xlen-1:0] operand1_o,
    output logic [xlen-1:0] operand2_o,
    output logic [xlen-1:0] operand3_o
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm;

    ////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////

    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        case (fmt_i)
            i_type:  imm = imm_i;
            s_type:  imm = imm_s;
            b_type:  imm = imm_b;
            u_type:  imm = imm_u;
            j_type:  imm = imm_j;
            // R has no immediate
            default: imm = '0;
        endcase
    end

    ////////////////////////////////////////
    // Operand routing
    ////////////////////////////////////////

    always_comb begin
        operand1_o = rs1_data_i;
        operand2_o = imm;
        operand3_o = imm;
        case (fmt_i)
            u_type, j_type: begin
                operand1_o = pc_i;
            end
            r_type, b_type: begin
                operand2_o = rs2_data_i;
            end
            // Store data goes out on the third operand
            s_type: begin
                operand3_o = rs2_data_i;
            end
            // I keeps rs1, imm, imm
            default: ;
        endcase
    end

endmodule

// File: hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    // Datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    ////////////////////////////////////////
    // Operations
    ////////////////////////////////////////

    // op_nop covers the bubble and FENCE
    typedef enum logic [5:0] {
        op_nop,
        op_lui,
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_jal,
        op_jalr,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw,
        op_invalid
    } op_e;

    ////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        r_type,
        i_type,
        s_type,
        b_type,
        u_type,
        j_type
    } format_e;

    // Major opcodes, bits 6 to 0
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_misc_mem = 7'b0001111;

endpackage

// File: testbench/decode_chk.sv
`timescale 1ns/100ps

module decode_chk
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enable_i,
    input  logic        hazard_i,
    input  op_e         op_i,
    input  logic [31:0] operand1_i,
    input  logic [31:0] operand2_i,
    input  logic [31:0] operand3_i,
    input  logic        illegal_i,
    input  logic        misaligned_i
);

    // Read by the testbench top at the end of the run
    int fail_count = 0;

    // No hazard while the stage is frozen
    assert property (@(posedge clk) disable iff (reset) !enable_i |-> !hazard_i)
        else begin
            fail_count++;
            $error("hazard raised while enable is low");
        end

    // A hazard loads a bubble
    assert property (@(posedge clk) disable iff (reset)
        hazard_i |=> (op_i == op_nop && operand1_i == '0 && operand2_i == '0 &&
                      operand3_i == '0))
        else begin
            fail_count++;
            $error("no bubble after hazard");
        end

    assert property (@(posedge clk) reset |=> (!illegal_i && !misaligned_i))
        else begin
            fail_count++;
            $error("exception flags set after reset");
        end

endmodule

bind decode_stage decode_chk decode_chk_inst (
    .clk          (clk),
    .reset        (reset),
    .enable_i     (enable_i),
    .hazard_i     (hazard_o),
    .op_i         (op_o),
    .operand1_i   (operand1_o),
    .operand2_i   (operand2_o),
    .operand3_i   (operand3_o),
    .illegal_i    (exc_illegal_o),
    .misaligned_i (exc_misaligned_o)
);

// File: testbench/decode_monitor.sv
`timescale 1ns/100ps

module decode_monitor
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enable_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  op_e         row_op_i,
    input  format_e     row_fmt_i,
    input  logic        row_hazard_i,
    input  logic [31:0] reg_mult_i,
    input  logic [31:0] reg_offset_i,
    input  logic        hazard_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  op_e         op_i,
    input  logic [31:0] operand1_i,
    input  logic [31:0] operand2_i,
    input  logic [31:0] operand3_i,
    input  logic [31:0] pc_out_i,
    input  logic [31:0] instr_out_i,
    input  logic [4:0]  rd_i,
    input  logic        illegal_i,
    input  logic        misaligned_i,
    output int          error_count_o
);

    logic        have_exp = 1'b0;
    op_e         exp_op;
    logic [31:0] exp_op1;
    logic [31:0] exp_op2;
    logic [31:0] exp_op3;
    logic [31:0] exp_pc;
    logic [31:0] exp_instr;
    logic [4:0]  exp_rd;
    logic        exp_ill;
    logic        exp_mis;

    initial error_count_o = 0;

    function automatic logic [31:0] reg_value(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'h0;
        end
        return 32'(idx) * reg_mult_i + reg_offset_i;
    endfunction

    // Immediate bits as laid out in the base ISA
    function automatic logic [31:0] imm_value(input logic [31:0] in, input format_e fmt);
        case (fmt)
            i_type:  return {{20{in[31]}}, in[31:20]};
            s_type:  return {{20{in[31]}}, in[31:25], in[11:7]};
            b_type:  return {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
            u_type:  return {in[31:12], 12'h000};
            j_type:  return {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count_o++;
        end
    endtask

    ////////////////////////////////////////
    // Compare, then predict the next edge
    ////////////////////////////////////////

    always @(posedge clk) begin : predict
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        if (have_exp) begin
            check_value("op_o", 32'(exp_op), 32'(op_i));
            check_value("operand1_o", exp_op1, operand1_i);
            check_value("operand2_o", exp_op2, operand2_i);
            check_value("operand3_o", exp_op3, operand3_i);
            check_value("pc_o", exp_pc, pc_out_i);
            check_value("instr_o", exp_instr, instr_out_i);
            check_value("rd_o", 32'(exp_rd), 32'(rd_i));
            check_value("exc_illegal_o", 32'(exp_ill), 32'(illegal_i));
            check_value("exc_misaligned_o", 32'(exp_mis), 32'(misaligned_i));
        end
        if (!reset) begin
            check_value("hazard_o", 32'(row_hazard_i), 32'(hazard_i));
            check_value("rs1_o", 32'(instr_i[19:15]), 32'(rs1_i));
            check_value("rs2_o", 32'(instr_i[24:20]), 32'(rs2_i));
        end
        if (reset || row_hazard_i) begin
            // Idle values and bubble are the same
            exp_op    = op_nop;
            exp_op1   = '0;
            exp_op2   = '0;
            exp_op3   = '0;
            exp_pc    = '0;
            exp_instr = '0;
            exp_rd    = '0;
            exp_ill   = 1'b0;
            exp_mis   = 1'b0;
            if (reset) begin
                have_exp = 1'b1;
            end
        end else if (enable_i) begin
            rs1_val = reg_value(instr_i[19:15]);
            rs2_val = reg_value(instr_i[24:20]);
            imm     = imm_value(instr_i, row_fmt_i);
            case (row_fmt_i)
                u_type, j_type: begin
                    exp_op1 = pc_i;
                    exp_op2 = imm;
                    exp_op3 = imm;
                end
                r_type, b_type: begin
                    exp_op1 = rs1_val;
                    exp_op2 = rs2_val;
                    exp_op3 = imm;
                end
                s_type: begin
                    exp_op1 = rs1_val;
                    exp_op2 = imm;
                    exp_op3 = rs2_val;
                end
                default: begin
                    exp_op1 = rs1_val;
                    exp_op2 = imm;
                    exp_op3 = imm;
                end
            endcase
            exp_op    = row_op_i;
            exp_pc    = pc_i;
            exp_instr = instr_i;
            exp_rd    = (row_fmt_i == s_type || row_fmt_i == b_type) ? 5'd0 : instr_i[11:7];
            exp_ill   = (row_op_i == op_invalid);
            exp_mis   = (pc_i[1:0] != 2'b00);
        end
    end

endmodule

// File: testbench/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage
    import rv_decode_pkg::*;
();

    localparam int          clk_period = 40;
    localparam int          max_rows   = 80;
    localparam logic [31:0] reg_mult   = 32'h0001_0003;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        hazard;
    op_e         op_out;
    logic [31:0] operand1;
    logic [31:0] operand2;
    logic [31:0] operand3;
    logic [31:0] pc_out;
    logic [31:0] instr_out;
    logic [4:0]  rd;
    logic        exc_illegal;
    logic        exc_misaligned;

    op_e         row_op;
    format_e     row_fmt;
    logic        row_hazard;
    logic [31:0] pc_base;
    logic [31:0] reg_offset;
    int          monitor_errors;
    int          n_rows;
    logic        rows_ready;

    // Stimulus table
    logic [31:0] tab_instr [max_rows];
    logic [31:0] tab_pc [max_rows];
    logic        tab_en [max_rows];
    op_e         tab_op [max_rows];
    format_e     tab_fmt [max_rows];
    logic        tab_hz [max_rows];

    always #(clk_period / 2) clk = ~clk;

    decode_stage decode_stage_inst (
        .clk              (clk),
        .reset            (reset),
        .enable_i         (enable),
        .instr_i          (instr),
        .pc_i             (pc),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .hazard_o         (hazard),
        .op_o             (op_out),
        .operand1_o       (operand1),
        .operand2_o       (operand2),
        .operand3_o       (operand3),
        .pc_o             (pc_out),
        .instr_o          (instr_out),
        .rd_o             (rd),
        .exc_illegal_o    (exc_illegal),
        .exc_misaligned_o (exc_misaligned)
    );

    decode_monitor decode_monitor_inst (
        .clk           (clk),
        .reset         (reset),
        .enable_i      (enable),
        .instr_i       (instr),
        .pc_i          (pc),
        .row_op_i      (row_op),
        .row_fmt_i     (row_fmt),
        .row_hazard_i  (row_hazard),
        .reg_mult_i    (reg_mult),
        .reg_offset_i  (reg_offset),
        .hazard_i      (hazard),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .op_i          (op_out),
        .operand1_i    (operand1),
        .operand2_i    (operand2),
        .operand3_i    (operand3),
        .pc_out_i      (pc_out),
        .instr_out_i   (instr_out),
        .rd_i          (rd),
        .illegal_i     (exc_illegal),
        .misaligned_i  (exc_misaligned),
        .error_count_o (monitor_errors)
    );

    ////////////////////////////////////////
    // Register file model
    ////////////////////////////////////////

    function automatic logic [31:0] reg_value(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'h0;
        end
        return 32'(idx) * reg_mult + reg_offset;
    endfunction

    assign rs1_data = reg_value(rs1);
    assign rs2_data = reg_value(rs2);

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] s2,
                                          input logic [4:0] s1, input logic [2:0] f3,
                                          input logic [4:0] d, input logic [6:0] opc);
        return {f7, s2, s1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] s1,
                                          input logic [2:0] f3, input logic [4:0] d,
                                          input logic [6:0] opc);
        return {imm, s1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] s2,
                                          input logic [4:0] s1, input logic [2:0] f3);
        return {imm[11:5], s2, s1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] s2,
                                          input logic [4:0] s1, input logic [2:0] f3);
        return {imm[12], imm[10:5], s2, s1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] d);
        return {imm[20], imm[10:1], imm[11], imm[19:12], d, opc_jal};
    endfunction

    task automatic add_row(input logic [31:0] in, input logic en, input logic [1:0] mis,
                           input op_e op, input format_e fmt, input logic hz);
        tab_instr[n_rows] = in;
        tab_pc[n_rows]    = pc_base + 32'(n_rows * 4) + {30'b0, mis};
        tab_en[n_rows]    = en;
        tab_op[n_rows]    = op;
        tab_fmt[n_rows]   = fmt;
        tab_hz[n_rows]    = hz;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        add_row({20'hABCDE, 5'd1, opc_lui}, 1, 0, op_lui, u_type, 0);
        add_row({20'h12345, 5'd2, opc_auipc}, 1, 0, op_add, u_type, 0);
        add_row(enc_j(21'h1FFFF8, 5'd3), 1, 0, op_jal, j_type, 0);
        add_row(enc_i(12'hFFC, 10, 3'b000, 4, opc_jalr), 1, 0, op_jalr, i_type, 0);
        add_row(enc_b(13'h0010, 11, 10, 3'b000), 1, 0, op_beq, b_type, 0);
        add_row(enc_b(13'h1FE0, 11, 10, 3'b001), 1, 0, op_bne, b_type, 0);
        add_row(enc_b(13'h0FFE, 11, 10, 3'b100), 1, 0, op_blt, b_type, 0);
        add_row(enc_b(13'h1002, 11, 10, 3'b101), 1, 0, op_bge, b_type, 0);
        add_row(enc_b(13'h0024, 11, 10, 3'b110), 1, 0, op_bltu, b_type, 0);
        add_row(enc_b(13'h1FFC, 11, 10, 3'b111), 1, 0, op_bgeu, b_type, 0);
        add_row(enc_i(12'h7FF, 12, 3'b000, 5, opc_load), 1, 0, op_lb, i_type, 0);
        add_row(enc_i(12'h010, 12, 3'b001, 5, opc_load), 1, 0, op_lh, i_type, 0);
        add_row(enc_i(12'hFFF, 12, 3'b010, 5, opc_load), 1, 0, op_lw, i_type, 0);
        add_row(enc_i(12'h800, 12, 3'b100, 5, opc_load), 1, 0, op_lbu, i_type, 0);
        add_row(enc_i(12'h123, 12, 3'b101, 5, opc_load), 1, 0, op_lhu, i_type, 0);
        add_row(enc_s(12'h7E1, 13, 12, 3'b000), 1, 0, op_sb, s_type, 0);
        add_row(enc_s(12'h81F, 13, 12, 3'b001), 1, 0, op_sh, s_type, 0);
        add_row(enc_s(12'h004, 13, 12, 3'b010), 1, 0, op_sw, s_type, 0);
        // Load after store, then load after load
        add_row(enc_i(12'h004, 12, 3'b010, 6, opc_load), 1, 0, op_lw, i_type, 1);
        add_row(enc_i(12'h008, 12, 3'b010, 7, opc_load), 1, 0, op_lw, i_type, 0);
        add_row(enc_i(12'h9AB, 10, 3'b000, 8, opc_op_imm), 1, 0, op_add, i_type, 0);
        add_row(enc_i(12'h001, 10, 3'b010, 9, opc_op_imm), 1, 0, op_slt, i_type, 0);
        add_row(enc_i(12'hFFF, 10, 3'b011, 1, opc_op_imm), 1, 0, op_sltu, i_type, 0);
        add_row(enc_i(12'h555, 10, 3'b100, 2, opc_op_imm), 1, 0, op_xor, i_type, 0);
        add_row(enc_i(12'h0F0, 10, 3'b110, 3, opc_op_imm), 1, 0, op_or, i_type, 0);
        add_row(enc_i(12'hF0F, 10, 3'b111, 4, opc_op_imm), 1, 0, op_and, i_type, 0);
        add_row(enc_i(12'h003, 10, 3'b001, 5, opc_op_imm), 1, 0, op_sll, i_type, 0);
        add_row(enc_i(12'h005, 10, 3'b101, 6, opc_op_imm), 1, 0, op_srl, i_type, 0);
        add_row(enc_i(12'h404, 10, 3'b101, 7, opc_op_imm), 1, 0, op_sra, i_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b000, 8, opc_op), 1, 0, op_add, r_type, 0);
        add_row(enc_r(7'h20, 11, 10, 3'b000, 9, opc_op), 1, 0, op_sub, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b001, 1, opc_op), 1, 0, op_sll, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b010, 2, opc_op), 1, 0, op_slt, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b011, 3, opc_op), 1, 0, op_sltu, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b100, 4, opc_op), 1, 0, op_xor, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b101, 5, opc_op), 1, 0, op_srl, r_type, 0);
        add_row(enc_r(7'h20, 11, 10, 3'b101, 6, opc_op), 1, 0, op_sra, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b110, 7, opc_op), 1, 0, op_or, r_type, 0);
        add_row(enc_r(7'h00, 11, 10, 3'b111, 8, opc_op), 1, 0, op_and, r_type, 0);
        add_row(32'h0FF0000F, 1, 0, op_nop, r_type, 0);
        // Illegal: ECALL, MUL, bad load width, bad shift funct7
        add_row(32'h00000073, 1, 0, op_invalid, r_type, 0);
        add_row(enc_r(7'h01, 11, 10, 3'b000, 9, opc_op), 1, 0, op_invalid, r_type, 0);
        add_row(enc_i(12'h000, 12, 3'b011, 1, opc_load), 1, 0, op_invalid, i_type, 0);
        add_row(enc_i(12'h402, 10, 3'b001, 2, opc_op_imm), 1, 0, op_invalid, i_type, 0);
        // Read-after-write on rs1, then on rs2
        add_row(enc_r(7'h00, 11, 10, 3'b000, 3, opc_op), 1, 0, op_add, r_type, 0);
        add_row(enc_r(7'h00, 11, 3, 3'b000, 4, opc_op), 1, 0, op_add, r_type, 1);
        add_row(enc_r(7'h00, 4, 10, 3'b000, 5, opc_op), 1, 0, op_add, r_type, 1);
        // Unused source fields match the lock
        add_row({20'h00028, 5'd6, opc_lui}, 1, 0, op_lui, u_type, 0);
        add_row(enc_i(12'h006, 10, 3'b000, 7, opc_op_imm), 1, 0, op_add, i_type, 0);
        // x0 never locks
        add_row(enc_r(7'h00, 11, 10, 3'b000, 0, opc_op), 1, 0, op_add, r_type, 0);
        add_row(enc_r(7'h00, 0, 0, 3'b000, 1, opc_op), 1, 0, op_add, r_type, 0);
        // Two stall cycles on a dependent instruction, the lock holds through them
        add_row(enc_r(7'h00, 11, 1, 3'b000, 2, opc_op), 0, 0, op_add, r_type, 0);
        add_row(enc_r(7'h00, 11, 1, 3'b000, 2, opc_op), 0, 0, op_add, r_type, 0);
        add_row(enc_r(7'h00, 11, 1, 3'b000, 2, opc_op), 1, 0, op_add, r_type, 1);
        add_row(enc_i(12'h005, 10, 3'b000, 3, opc_op_imm), 1, 2, op_add, i_type, 0);
        add_row(enc_i(12'hFF9, 11, 3'b000, 8, opc_op_imm), 1, 1, op_add, i_type, 0);
        add_row(32'h0FF0000F, 1, 0, op_nop, r_type, 0);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int i;
        clk        = 1'b0;
        reset      = 1'b1;
        enable     = 1'b0;
        instr      = '0;
        pc         = '0;
        row_op     = op_nop;
        row_fmt    = r_type;
        row_hazard = 1'b0;
        rows_ready = 1'b0;
        pc_base    = $urandom(81663) & 32'h00FF_FFF0;
        reg_offset = $urandom & 32'h0000_FFFF;
        build_table();
        rows_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        i = 0;
        while (i < n_rows) begin
            instr      <= tab_instr[i];
            pc         <= tab_pc[i];
            enable     <= tab_en[i];
            row_op     <= tab_op[i];
            row_fmt    <= tab_fmt[i];
            row_hazard <= tab_hz[i];
            @(posedge clk);
            if (hazard) begin
                // Row stays for its replay
                row_hazard <= 1'b0;
                @(posedge clk);
            end
            i++;
        end
        enable     <= 1'b0;
        row_hazard <= 1'b0;
        repeat (3) @(posedge clk);
        $display("Done: %0d rows, %0d monitor errors, %0d assertion failures",
                 n_rows, monitor_errors, decode_stage_inst.decode_chk_inst.fail_count);
        if (monitor_errors == 0 && decode_stage_inst.decode_chk_inst.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (rows_ready);
        #((n_rows * 3 + 20) * clk_period);
        $display("Timeout: the run did not finish in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
